/* source/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // data and address width
    localparam int XLEN = 64;

    // byte lanes in one word
    localparam int LANES = XLEN / 8;

    // low address bits that pick a lane
    localparam int LANE_BITS = $clog2(LANES);

    // memop field, same encoding as funct3
    typedef logic [2:0] memop_t;

    // load codes
    // bit 2 set means zero extension
    localparam memop_t MEMOP_LB  = 3'd0;
    localparam memop_t MEMOP_LH  = 3'd1;
    localparam memop_t MEMOP_LW  = 3'd2;
    localparam memop_t MEMOP_LD  = 3'd3;
    localparam memop_t MEMOP_LBU = 3'd4;
    localparam memop_t MEMOP_LHU = 3'd5;
    localparam memop_t MEMOP_LWU = 3'd6;

    // store codes
    // low two bits give log2 of the access size in bytes
    localparam memop_t MEMOP_SB  = 3'd0;
    localparam memop_t MEMOP_SH  = 3'd1;
    localparam memop_t MEMOP_SW  = 3'd2;
    localparam memop_t MEMOP_SD  = 3'd3;

endpackage

`default_nettype wire

/* source/sram_byte_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module sram_byte_bank #(
    parameter  int DEPTH_WORDS = 256,
    localparam int IDX_W       = $clog2(DEPTH_WORDS)
) (
    input  wire               clk,
    input  wire [IDX_W-1:0]   bank_idx_i,
    input  wire               bank_rd_en_i,
    input  wire               bank_we_i,
    input  wire [7:0]         bank_wdata_i,
    output logic [7:0]        bank_rdata_o
);

    // one byte per word of the memory
    logic [7:0] mem [0:DEPTH_WORDS-1];

    // write port
    always_ff @(posedge clk) begin
        if (bank_we_i) begin
            mem[bank_idx_i] <= bank_wdata_i;
        end
    end

    // registered read
    // output holds its value between reads
    always_ff @(posedge clk) begin
        if (bank_rd_en_i) begin
            bank_rdata_o <= mem[bank_idx_i];
        end
    end

endmodule

`default_nettype wire

/* source/sram_port_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module sram_port_ctrl
    import lsu_pkg::*;
#(
    parameter  int DEPTH_WORDS = 256,
    localparam int IDX_W       = $clog2(DEPTH_WORDS)
) (
    input  wire                        clk,
    input  wire                        rst_n_i,

    // from the lsu
    input  wire [XLEN-1:0]             ls_sram_addr_i,
    input  wire                        ls_sram_rd_en_i,
    input  wire                        ls_sram_wr_en_i,
    input  wire [XLEN-1:0]             ls_sram_wr_data_i,
    input  wire [LANES-1:0]            ls_sram_wr_mask_i,
    output logic                       ls_sram_rd_data_valid_o,
    output logic                       ls_sram_wr_data_ok_o,

    // to the byte banks
    output logic [IDX_W-1:0]           bank_idx_o,
    output logic                       bank_rd_en_o,
    output logic [LANES-1:0]           bank_we_o,
    output logic [LANES-1:0][7:0]      bank_wdata_o
);

    logic rd_accept;
    logic wr_accept;
    // a response is due in the current cycle
    logic pending;
    // pending response is a read
    logic pend_rd;

    // one access in flight at a time
    // a held enable is ignored while its response is out
    assign rd_accept = ls_sram_rd_en_i & ~pending;
    assign wr_accept = ls_sram_wr_en_i & ~pending;

    // drop lane bits to get the word index
    assign bank_idx_o   = ls_sram_addr_i[LANE_BITS +: IDX_W];
    assign bank_rd_en_o = rd_accept;

    // per lane write enable and data byte
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            bank_we_o[k]    = wr_accept & ls_sram_wr_mask_i[k];
            bank_wdata_o[k] = ls_sram_wr_data_i[8*k +: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending <= 1'b0;
            pend_rd <= 1'b0;
        end else begin
            // set for exactly one cycle after an accept
            pending <= rd_accept | wr_accept;
            pend_rd <= rd_accept;
        end
    end

    // bank read register is loaded by now
    assign ls_sram_rd_data_valid_o = pending & pend_rd;
    assign ls_sram_wr_data_ok_o    = pending & ~pend_rd;

endmodule

`default_nettype wire

/* source/lsu.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu
    import lsu_pkg::*;
(
    // requester side
    input  wire                   rden_i,
    input  wire                   wren_i,
    input  wire memop_t           memop_i,
    input  wire [XLEN-1:0]        addr_i,
    input  wire [XLEN-1:0]        wr_data_i,
    output logic [XLEN-1:0]       ls_res_o,
    output logic                  ls_done_o,
    output logic                  ls_misalign_o,

    // memory side
    output logic [XLEN-1:0]       ls_sram_addr_o,
    output logic                  ls_sram_rd_en_o,
    output logic                  ls_sram_wr_en_o,
    output logic [XLEN-1:0]       ls_sram_wr_data_o,
    output logic [LANES-1:0]      ls_sram_wr_mask_o,
    input  wire                   ls_sram_rd_data_valid_i,
    input  wire                   ls_sram_wr_data_ok_i,
    input  wire [XLEN-1:0]        ls_sram_rd_data_i
);

    // log2 of access size in bytes
    logic [1:0]           size;
    // lane of the lowest addressed byte
    logic [LANE_BITS-1:0] lane;
    // address bits that must be zero for this size
    logic [LANE_BITS-1:0] align_bits;
    // unshifted byte mask for this size
    logic [LANES-1:0]     base_mask;
    logic                 req;
    logic                 misaligned;
    logic                 rd_go;
    logic                 wr_go;
    logic                 load_done;
    // returned word with the addressed bytes moved down to lane 0
    logic [XLEN-1:0]      rd_shifted;
    logic [7:0]           rd_b;
    logic [15:0]          rd_h;
    logic [31:0]          rd_w;
    // one-hot load selects, only live in the done cycle
    logic                 lb;
    logic                 lbu;
    logic                 lh;
    logic                 lhu;
    logic                 lw;
    logic                 lwu;
    logic                 ld;

    // size field is shared by loads and stores
    assign size = memop_i[1:0];
    assign lane = addr_i[LANE_BITS-1:0];
    assign req  = rden_i | wren_i;

    always_comb begin
        case (size)
            2'd0: begin
                base_mask  = 8'b0000_0001;
                align_bits = 3'b000;
            end
            2'd1: begin
                base_mask  = 8'b0000_0011;
                align_bits = 3'b001;
            end
            2'd2: begin
                base_mask  = 8'b0000_1111;
                align_bits = 3'b011;
            end
            default: begin
                base_mask  = 8'b1111_1111;
                align_bits = 3'b111;
            end
        endcase
    end

    // natural alignment only
    assign misaligned    = |(lane & align_bits);
    assign ls_misalign_o = req & misaligned;

    // misaligned accesses never reach the memory
    assign rd_go = rden_i & ~misaligned;
    assign wr_go = wren_i & ~misaligned;

    assign ls_sram_addr_o  = addr_i;
    assign ls_sram_rd_en_o = rd_go;
    assign ls_sram_wr_en_o = wr_go;

    // move mask and store data up into the addressed lanes
    assign ls_sram_wr_mask_o = {LANES{wr_go}} & (base_mask << lane);
    assign ls_sram_wr_data_o = wr_data_i << {lane, 3'b000};

    // memory strobes, or immediate finish on misalign
    assign load_done = rden_i & ls_sram_rd_data_valid_i;
    assign ls_done_o = load_done
                     | (wren_i & ls_sram_wr_data_ok_i)
                     | ls_misalign_o;

    // load side
    assign rd_shifted = ls_sram_rd_data_i >> {lane, 3'b000};
    assign rd_b       = rd_shifted[7:0];
    assign rd_h       = rd_shifted[15:0];
    assign rd_w       = rd_shifted[31:0];

    assign lb  = load_done & (memop_i == MEMOP_LB);
    assign lbu = load_done & (memop_i == MEMOP_LBU);
    assign lh  = load_done & (memop_i == MEMOP_LH);
    assign lhu = load_done & (memop_i == MEMOP_LHU);
    assign lw  = load_done & (memop_i == MEMOP_LW);
    assign lwu = load_done & (memop_i == MEMOP_LWU);
    assign ld  = load_done & (memop_i == MEMOP_LD);

    // or-merge of the extended candidates
    // result stays zero outside a load completion
    assign ls_res_o = {XLEN{1'b0}}
                    | ({XLEN{lb}}  & {{(XLEN-8){rd_b[7]}}, rd_b})
                    | ({XLEN{lbu}} & {{(XLEN-8){1'b0}}, rd_b})
                    | ({XLEN{lh}}  & {{(XLEN-16){rd_h[15]}}, rd_h})
                    | ({XLEN{lhu}} & {{(XLEN-16){1'b0}}, rd_h})
                    | ({XLEN{lw}}  & {{(XLEN-32){rd_w[31]}}, rd_w})
                    | ({XLEN{lwu}} & {{(XLEN-32){1'b0}}, rd_w})
                    | ({XLEN{ld}}  & ls_sram_rd_data_i);

endmodule

`default_nettype wire

/* source/lsu_sram_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_sram_top
    import lsu_pkg::*;
#(
    parameter int DEPTH_WORDS = 256
) (
    input  wire                clk,
    input  wire                rst_n_i,
    input  wire                rden_i,
    input  wire                wren_i,
    input  wire memop_t        memop_i,
    input  wire [XLEN-1:0]     addr_i,
    input  wire [XLEN-1:0]     wr_data_i,
    output logic [XLEN-1:0]    ls_res_o,
    output logic               ls_done_o,
    output logic               ls_misalign_o
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    // lsu to port controller
    logic [XLEN-1:0]           ls_sram_addr;
    logic                      ls_sram_rd_en;
    logic                      ls_sram_wr_en;
    logic [XLEN-1:0]           ls_sram_wr_data;
    logic [LANES-1:0]          ls_sram_wr_mask;
    logic                      ls_sram_rd_data_valid;
    logic                      ls_sram_wr_data_ok;
    logic [XLEN-1:0]           ls_sram_rd_data;

    // port controller to banks
    logic [IDX_W-1:0]          bank_idx;
    logic                      bank_rd_en;
    logic [LANES-1:0]          bank_we;
    logic [LANES-1:0][7:0]     bank_wdata;
    logic [LANES-1:0][7:0]     bank_rdata;

    lsu i_lsu (
        .rden_i                  (rden_i),
        .wren_i                  (wren_i),
        .memop_i                 (memop_i),
        .addr_i                  (addr_i),
        .wr_data_i               (wr_data_i),
        .ls_res_o                (ls_res_o),
        .ls_done_o               (ls_done_o),
        .ls_misalign_o           (ls_misalign_o),
        .ls_sram_addr_o          (ls_sram_addr),
        .ls_sram_rd_en_o         (ls_sram_rd_en),
        .ls_sram_wr_en_o         (ls_sram_wr_en),
        .ls_sram_wr_data_o       (ls_sram_wr_data),
        .ls_sram_wr_mask_o       (ls_sram_wr_mask),
        .ls_sram_rd_data_valid_i (ls_sram_rd_data_valid),
        .ls_sram_wr_data_ok_i    (ls_sram_wr_data_ok),
        .ls_sram_rd_data_i       (ls_sram_rd_data)
    );

    sram_port_ctrl #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_port_ctrl (
        .clk                     (clk),
        .rst_n_i                 (rst_n_i),
        .ls_sram_addr_i          (ls_sram_addr),
        .ls_sram_rd_en_i         (ls_sram_rd_en),
        .ls_sram_wr_en_i         (ls_sram_wr_en),
        .ls_sram_wr_data_i       (ls_sram_wr_data),
        .ls_sram_wr_mask_i       (ls_sram_wr_mask),
        .ls_sram_rd_data_valid_o (ls_sram_rd_data_valid),
        .ls_sram_wr_data_ok_o    (ls_sram_wr_data_ok),
        .bank_idx_o              (bank_idx),
        .bank_rd_en_o            (bank_rd_en),
        .bank_we_o               (bank_we),
        .bank_wdata_o            (bank_wdata)
    );

    // one bank per byte lane
    for (genvar k = 0; k < LANES; k++) begin : g_bank
        sram_byte_bank #(
            .DEPTH_WORDS (DEPTH_WORDS)
        ) i_bank (
            .clk          (clk),
            .bank_idx_i   (bank_idx),
            .bank_rd_en_i (bank_rd_en),
            .bank_we_i    (bank_we[k]),
            .bank_wdata_i (bank_wdata[k]),
            .bank_rdata_o (bank_rdata[k])
        );
    end

    // lane 0 lands in the low byte of the read word
    assign ls_sram_rd_data = bank_rdata;

endmodule

`default_nettype wire

/* sim/tb_lsu_vectors.svh */
// columns: name, write (1) or read (0), memop, address, data
// data is ignored on reads, expected load values come from the shadow

// full doubleword round trip
push_vector("sd_full",    1'b1, MEMOP_SD,  64'h000, 64'h0123_4567_89ab_cdef);
push_vector("ld_full",    1'b0, MEMOP_LD,  64'h000, 64'h0);

// byte lanes, upper data bits must not leak into the word
push_vector("sd_clear",   1'b1, MEMOP_SD,  64'h008, 64'h0);
push_vector("sb_lane0",   1'b1, MEMOP_SB,  64'h008, 64'hdead_beef_0000_0011);
push_vector("ld_lane0",   1'b0, MEMOP_LD,  64'h008, 64'h0);
push_vector("sb_lane1",   1'b1, MEMOP_SB,  64'h009, 64'hdead_beef_0000_0022);
push_vector("ld_lane1",   1'b0, MEMOP_LD,  64'h008, 64'h0);
push_vector("sb_lane2",   1'b1, MEMOP_SB,  64'h00a, 64'hdead_beef_0000_0033);
push_vector("ld_lane2",   1'b0, MEMOP_LD,  64'h008, 64'h0);
push_vector("sb_lane3",   1'b1, MEMOP_SB,  64'h00b, 64'hdead_beef_0000_0044);
push_vector("ld_lane3",   1'b0, MEMOP_LD,  64'h008, 64'h0);
push_vector("sb_lane4",   1'b1, MEMOP_SB,  64'h00c, 64'hdead_beef_0000_0055);
push_vector("ld_lane4",   1'b0, MEMOP_LD,  64'h008, 64'h0);
push_vector("sb_lane5",   1'b1, MEMOP_SB,  64'h00d, 64'hdead_beef_0000_0066);
push_vector("ld_lane5",   1'b0, MEMOP_LD,  64'h008, 64'h0);
push_vector("sb_lane6",   1'b1, MEMOP_SB,  64'h00e, 64'hdead_beef_0000_0077);
push_vector("ld_lane6",   1'b0, MEMOP_LD,  64'h008, 64'h0);
push_vector("sb_lane7",   1'b1, MEMOP_SB,  64'h00f, 64'hdead_beef_0000_00f8);
push_vector("ld_lane7",   1'b0, MEMOP_LD,  64'h008, 64'h0);

// sign versus zero extension, top bit set in every field
push_vector("sd_ext",     1'b1, MEMOP_SD,  64'h010, 64'hfedc_ba98_8765_4321);
push_vector("lb_neg",     1'b0, MEMOP_LB,  64'h013, 64'h0);
push_vector("lbu_neg",    1'b0, MEMOP_LBU, 64'h013, 64'h0);
push_vector("lh_neg",     1'b0, MEMOP_LH,  64'h016, 64'h0);
push_vector("lhu_neg",    1'b0, MEMOP_LHU, 64'h016, 64'h0);
push_vector("lw_neg",     1'b0, MEMOP_LW,  64'h014, 64'h0);
push_vector("lwu_neg",    1'b0, MEMOP_LWU, 64'h014, 64'h0);
push_vector("lw_low",     1'b0, MEMOP_LW,  64'h010, 64'h0);
push_vector("ld_ext",     1'b0, MEMOP_LD,  64'h010, 64'h0);

// misaligned accesses, memory must stay as stored
push_vector("sd_mis",     1'b1, MEMOP_SD,  64'h018, 64'h1122_3344_5566_7788);
push_vector("lh_mis",     1'b0, MEMOP_LH,  64'h019, 64'h0);
push_vector("lw_mis",     1'b0, MEMOP_LW,  64'h01a, 64'h0);
push_vector("ld_mis",     1'b0, MEMOP_LD,  64'h01c, 64'h0);
push_vector("sh_mis",     1'b1, MEMOP_SH,  64'h01b, 64'haaaa_aaaa_aaaa_aaaa);
push_vector("sw_mis",     1'b1, MEMOP_SW,  64'h01e, 64'hbbbb_bbbb_bbbb_bbbb);
push_vector("sd_mis_st",  1'b1, MEMOP_SD,  64'h01c, 64'hcccc_cccc_cccc_cccc);
push_vector("ld_after",   1'b0, MEMOP_LD,  64'h018, 64'h0);

/* sim/tb_lsu_sram.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_sram
    import lsu_pkg::*;
();

    localparam int          DEPTH_WORDS = 256;
    localparam int          MEM_BYTES   = DEPTH_WORDS * LANES;
    localparam int          CLK_PERIOD  = 100;
    // sample point a quarter period after the falling edge
    localparam int          SETTLE      = CLK_PERIOD / 4;
    localparam int          RAND_INIT   = 8;
    localparam int          RAND_OPS    = 32;
    localparam logic [63:0] RAND_BASE   = 64'h400;

    logic                clk;
    logic                rst_n;
    logic                rden;
    logic                wren;
    memop_t              memop;
    logic [XLEN-1:0]     addr;
    logic [XLEN-1:0]     wr_data;
    logic [XLEN-1:0]     ls_res;
    logic                ls_done;
    logic                ls_misalign;

    // stimulus table filled from the vector include
    string               vec_name [$];
    bit                  vec_wr [$];
    memop_t              vec_op [$];
    logic [XLEN-1:0]     vec_addr [$];
    logic [XLEN-1:0]     vec_data [$];

    // byte-wise reference copy of the memory
    logic [7:0]          shadow [0:MEM_BYTES-1];

    int                  errors;
    int                  ops_run;
    int                  cycle_count;
    int                  timeout_cycles;

    lsu_sram_top #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_dut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .rden_i        (rden),
        .wren_i        (wren),
        .memop_i       (memop),
        .addr_i        (addr),
        .wr_data_i     (wr_data),
        .ls_res_o      (ls_res),
        .ls_done_o     (ls_done),
        .ls_misalign_o (ls_misalign)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // run limit of 8 cycles per operation plus slack for reset
    always @(posedge clk) begin
        cycle_count++;
        if (timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic push_vector(input string name, input bit wr, input memop_t op,
                               input logic [XLEN-1:0] a, input logic [XLEN-1:0] d);
        vec_name.push_back(name);
        vec_wr.push_back(wr);
        vec_op.push_back(op);
        vec_addr.push_back(a);
        vec_data.push_back(d);
    endtask

    task automatic build_table;
        `include "tb_lsu_vectors.svh"
    endtask

    // natural alignment with size in bytes from the low memop bits
    function automatic bit is_misaligned(input memop_t op, input logic [XLEN-1:0] a);
        int nbytes;
        nbytes = 1 << op[1:0];
        return (a % nbytes) != 0;
    endfunction

    // gather bytes from the shadow then extend by memop bit 2
    function automatic logic [XLEN-1:0] expected_load(input memop_t op,
                                                      input logic [XLEN-1:0] a);
        int              nbytes;
        int              base;
        logic [XLEN-1:0] raw;
        nbytes = 1 << op[1:0];
        base   = int'(a % MEM_BYTES);
        raw    = '0;
        for (int k = 0; k < nbytes; k++) begin
            raw[8*k +: 8] = shadow[(base + k) % MEM_BYTES];
        end
        if (!op[2] && raw[8*nbytes-1]) begin
            for (int k = nbytes; k < LANES; k++) begin
                raw[8*k +: 8] = 8'hff;
            end
        end
        return raw;
    endfunction

    task automatic run_op(input string name, input bit wr, input memop_t op,
                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] d);
        bit              mis;
        int              waited;
        int              base;
        logic [XLEN-1:0] exp_res;
        mis     = is_misaligned(op, a);
        exp_res = (wr || mis) ? '0 : expected_load(op, a);
        ops_run++;
        @(negedge clk);
        rden    = ~wr;
        wren    = wr;
        memop   = op;
        addr    = a;
        wr_data = d;
        #(SETTLE);
        if (mis) begin
            // finishes in the enable cycle and leaves memory untouched
            if (ls_done !== 1'b1) begin
                errors++;
                $display("%s: done did not rise in the enable cycle of a misaligned access",
                         name);
            end
            if (ls_misalign !== 1'b1) begin
                errors++;
                $display("%s: misalign flag not raised", name);
            end
            if (ls_res !== '0) begin
                errors++;
                $display("Mismatch %s: expected %h, actual %h", name, exp_res, ls_res);
            end
        end else begin
            if (ls_done !== 1'b0) begin
                errors++;
                $display("%s: done rose in the enable cycle of an aligned access", name);
            end
            if (ls_misalign !== 1'b0) begin
                errors++;
                $display("%s: misalign flag raised on an aligned access", name);
            end
            waited = 0;
            while (ls_done !== 1'b1) begin
                @(negedge clk);
                #(SETTLE);
                waited++;
            end
            if (waited != 1) begin
                errors++;
                $display("%s: done came %0d cycles after the enable, expected 1", name, waited);
            end
            if (ls_res !== exp_res) begin
                errors++;
                $display("Mismatch %s: expected %h, actual %h", name, exp_res, ls_res);
            end
            if (wr) begin
                base = int'(a % MEM_BYTES);
                for (int k = 0; k < (1 << op[1:0]); k++) begin
                    shadow[(base + k) % MEM_BYTES] = d[8*k +: 8];
                end
            end
        end
        // drop the enable for one idle cycle
        @(negedge clk);
        rden = 1'b0;
        wren = 1'b0;
    endtask

    initial begin
        logic [1:0]      sz;
        logic [2:0]      ln;
        bit              wr;
        bit              uns;
        int              word;
        memop_t          op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] d;
        errors         = 0;
        ops_run        = 0;
        cycle_count    = 0;
        timeout_cycles = 0;
        rst_n          = 1'b0;
        rden           = 1'b0;
        wren           = 1'b0;
        // misaligned ld pattern behind low enables
        memop          = MEMOP_LD;
        addr           = 64'h1;
        wr_data        = '0;
        void'($urandom(32'h37ce));
        build_table();
        timeout_cycles = 8 * (vec_name.size() + RAND_INIT + RAND_OPS) + 50;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #(SETTLE);
        if (ls_done !== 1'b0 || ls_misalign !== 1'b0) begin
            errors++;
            $display("done or misalign high right after reset");
        end

        // directed table
        for (int i = 0; i < vec_name.size(); i++) begin
            run_op(vec_name[i], vec_wr[i], vec_op[i], vec_addr[i], vec_data[i]);
        end

        // random region gets fully written before any random load
        for (int i = 0; i < RAND_INIT; i++) begin
            run_op($sformatf("rand_init_%0d", i), 1'b1, MEMOP_SD,
                   RAND_BASE + 64'(i * 8), {$urandom, $urandom});
        end
        for (int i = 0; i < RAND_OPS; i++) begin
            sz   = 2'($urandom_range(3, 0));
            wr   = 1'($urandom_range(1, 0));
            uns  = 1'($urandom_range(1, 0));
            word = $urandom_range(RAND_INIT - 1, 0);
            ln   = 3'($urandom_range(7, 0));
            // clear low lane bits for natural alignment
            ln   = (ln >> sz) << sz;
            if (sz == 2'd3 || wr) begin
                uns = 1'b0;
            end
            op = {uns, sz};
            a  = RAND_BASE + 64'(word * 8) + 64'(ln);
            d  = {$urandom, $urandom};
            run_op($sformatf("rand_%0d", i), wr, op, a, d);
        end

        $display("operations: %0d, errors: %0d", ops_run, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+sim
source/lsu_pkg.sv
source/sram_byte_bank.sv
source/sram_port_ctrl.sv
source/lsu.sv
source/lsu_sram_top.sv
sim/tb_lsu_sram.sv

/* Makefile */
# Verilator build and run for the lsu with byte-bank memory

VERILATOR   ?= verilator
TOP         := tb_lsu_sram
FILELIST    := flist.f
OBJ_DIR     := obj_dir
LOG         := sim.log
BUILD_FLAGS := --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS  := --lint-only -Wall --timing --top-module $(TOP)
PASS_TEXT   := >>> PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := sim/tb_lsu_vectors.svh

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST)

# the log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF -- '$(PASS_TEXT)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
